//--- build.f
+incdir+include
design/scandoubler_pkg.sv
design/line_buffer.sv
design/input_line_capture.sv
design/output_line_timing.sv
design/scanline_mixer.sv
design/scandoubler_top.sv
testbench/scandoubler_tb.sv

//--- Bender.yml
package:
  name: scandoubler

export_include_dirs:
  - include

sources:
  # synthesizable core, package first
  - include_dirs:
      - include
    files:
      - design/scandoubler_pkg.sv
      - design/line_buffer.sv
      - design/input_line_capture.sv
      - design/output_line_timing.sv
      - design/scanline_mixer.sv
      - design/scandoubler_top.sv

  # testbench
  - target: simulation
    include_dirs:
      - include
    files:
      - testbench/scandoubler_tb.sv

//--- testbench/scandoubler_tb.sv
`timescale 1ns/1ps
`include "scandoubler_cfg.svh"

module scandoubler_tb;

	localparam int CLK_PERIOD = 20;
	localparam int CD = `SD_COLOR_DEPTH;
	localparam logic [2:0] DIV = 3'd3;
	// input line geometry in pixels and clk_sys cycles
	localparam int PIXELS = 40;
	localparam int LINE_CYCLES = (DIV + 1) * PIXELS;
	localparam int HS_CYCLES = 16;
	// active pixel range with blank on both sides of the line
	localparam int ACT_FIRST = 6;
	localparam int ACT_LAST = PIXELS - 4;
	localparam int TOTAL_LINES = 24;
	localparam int WATCHDOG_NS = (TOTAL_LINES + 4) * LINE_CYCLES * CLK_PERIOD;

	logic clk_sys;
	logic reset_i;
	logic bypass_i;
	scandoubler_pkg::ce_div_t ce_divider_i;
	scandoubler_pkg::scanline_mode_t scanlines_i;
	logic hb_i;
	logic vb_i;
	logic hs_i;
	logic vs_i;
	scandoubler_pkg::rgb_in_t rgb_i;
	logic hb_o;
	logic vb_o;
	logic hs_o;
	logic vs_o;
	logic [5:0] r_o;
	logic [5:0] g_o;
	logic [5:0] b_o;
	logic pixel_ena_o;

	// ========================================
	// checker state
	// ========================================

	logic [31:0] lfsr_state;
	scandoubler_pkg::rgb_in_t pix [0:PIXELS-1];
	scandoubler_pkg::rgb_in_t last_pix [0:PIXELS-1];
	// -1 none, 0 idle after reset, 1 bypass, 2 doubled settling, 3 doubled checked
	int mode = -1;
	logic [17:0] exp_q [$];
	logic [17:0] exp_pix;
	int pe_count;
	int hs_falls;
	int cycle_no;
	int last_pe;
	logic hs_prev;
	logic vs_level;

	scandoubler_top uut (
		.clk_sys      (clk_sys),
		.reset_i      (reset_i),
		.bypass_i     (bypass_i),
		.ce_divider_i (ce_divider_i),
		.scanlines_i  (scanlines_i),
		.hb_i         (hb_i),
		.vb_i         (vb_i),
		.hs_i         (hs_i),
		.vs_i         (vs_i),
		.rgb_i        (rgb_i),
		.hb_o         (hb_o),
		.vb_o         (vb_o),
		.hs_o         (hs_o),
		.vs_o         (vs_o),
		.r_o          (r_o),
		.g_o          (g_o),
		.b_o          (b_o),
		.pixel_ena_o  (pixel_ena_o)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	// ========================================
	// helpers
	// ========================================

	// galois lfsr stepped once per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_state[0]};
			if (lfsr_state[0]) begin
				lfsr_state = (lfsr_state >> 1) ^ 32'h80200003;
			end else begin
				lfsr_state = lfsr_state >> 1;
			end
		end
		return v;
	endfunction

	// top bits repeated below the colour
	function automatic logic [5:0] widen(input logic [CD-1:0] c);
		return {c, c[CD-1 -: 6-CD]};
	endfunction

	function automatic logic [6:0] coeff_for(input scandoubler_pkg::scanline_mode_t sl);
		case (sl)
			scandoubler_pkg::SL_25: return 7'h3a;
			scandoubler_pkg::SL_50: return 7'h2e;
			scandoubler_pkg::SL_75: return 7'h1a;
			default: return 7'h40;
		endcase
	endfunction

	// widened value times coefficient keeping bits 11:6
	function automatic logic [17:0] expected_pixel(input scandoubler_pkg::rgb_in_t p,
		input logic [6:0] k);
		logic [12:0] r;
		logic [12:0] g;
		logic [12:0] b;
		r = widen(p.r) * k;
		g = widen(p.g) * k;
		b = widen(p.b) * k;
		return {r[11:6], g[11:6], b[11:6]};
	endfunction

	task automatic stop_on_failure();
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] e,
		input logic [31:0] a);
		$display("ERROR %s: expected 0x%0h, actual 0x%0h", name, e, a);
		stop_on_failure();
	endtask

	task automatic check_equal(input string name, input logic [31:0] e,
		input logic [31:0] a);
		assert (e === a) else report_mismatch(name, e, a);
	endtask

	// colour must be black in any blanking
	blank_is_black: assert property (@(posedge clk_sys) disable iff (reset_i)
		(hb_o || vb_o) |-> ({r_o, g_o, b_o} == '0))
		else report_mismatch("blank colour", 0, {r_o, g_o, b_o});

	// ========================================
	// line driver
	// ========================================

	// drives one input line after closing the checks of the line before
	task automatic drive_line(input int line_mode, input logic vb_level, input logic vs_lvl,
		input scandoubler_pkg::scanline_mode_t sl);
		logic [31:0] v;
		int n;
		@(posedge clk_sys);
		if (mode == 3) begin
			check_equal("colours per line", 0, exp_q.size());
			check_equal("hs_o falls per line", 2, hs_falls);
			check_equal("pixel_ena per line", LINE_CYCLES / 2, pe_count);
		end
		if (line_mode == 1 && mode != 1) begin
			last_pe = -1;
		end
		mode = line_mode;
		pe_count = 0;
		hs_falls = 0;
		exp_q.delete();
		// previous line comes out twice with the first half dimmed
		if (line_mode == 3) begin
			for (int half = 0; half < 2; half++) begin
				for (int i = ACT_FIRST; i < ACT_LAST; i++) begin
					exp_q.push_back(expected_pixel(last_pix[i],
						half == 0 ? coeff_for(sl) : 7'h40));
				end
			end
		end
		for (int i = 0; i < PIXELS; i++) begin
			v = rand_bits(3 * CD);
			pix[i] = v[3*CD-1:0];
		end
		bypass_i <= (line_mode == 1);
		scanlines_i <= sl;
		vs_i <= vs_lvl;
		for (int c = 0; c < LINE_CYCLES; c++) begin
			if (c > 0) begin
				@(posedge clk_sys);
			end
			n = (c == 0) ? PIXELS - 1 : (c - 1) / (DIV + 1);
			hs_i <= (c >= HS_CYCLES);
			hb_i <= !(c > 0 && n >= ACT_FIRST && n < ACT_LAST);
			vb_i <= vb_level;
			rgb_i <= pix[n];
		end
		last_pix = pix;
	endtask

	// ========================================
	// output monitor
	// ========================================

	always @(negedge clk_sys) begin
		cycle_no = cycle_no + 1;
		if (mode == 0) begin
			check_equal("idle after reset", 0,
				{hs_o, vs_o, hb_o, vb_o, pixel_ena_o, r_o, g_o, b_o});
		end else if (mode == 1) begin
			check_equal("bypass sync", {hb_i, vb_i, hs_i, vs_i}, {hb_o, vb_o, hs_o, vs_o});
			exp_pix = (hb_i || vb_i) ? '0 :
				{widen(rgb_i.r), widen(rgb_i.g), widen(rgb_i.b)};
			check_equal("bypass colour", exp_pix, {r_o, g_o, b_o});
			if (pixel_ena_o) begin
				if (last_pe >= 0) begin
					check_equal("bypass pixel_ena period", DIV + 1, cycle_no - last_pe);
				end
				last_pe = cycle_no;
			end
		end else if (mode == 3) begin
			if (hs_prev && !hs_o) begin
				hs_falls++;
			end
			if (pixel_ena_o) begin
				pe_count++;
				if (!hb_o && !vb_o) begin
					if (exp_q.size() == 0) begin
						$display("ERROR doubled colour: more visible pixels than the input line had");
						stop_on_failure();
					end else begin
						exp_pix = exp_q.pop_front();
						check_equal("doubled colour", exp_pix, {r_o, g_o, b_o});
					end
				end
			end
		end
		hs_prev = hs_o;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("ERROR watchdog: the run went on longer than all lines should take");
		stop_on_failure();
	end

	// ========================================
	// test sequence
	// ========================================

	initial begin
		lfsr_state = 32'd74264;
		reset_i = 1'b1;
		bypass_i = 1'b0;
		ce_divider_i = DIV;
		scanlines_i = scandoubler_pkg::SL_NONE;
		hb_i = 1'b0;
		vb_i = 1'b0;
		hs_i = 1'b1;
		vs_i = 1'b0;
		rgb_i = '0;
		mode = -1;
		pe_count = 0;
		hs_falls = 0;
		cycle_no = 0;
		last_pe = -1;
		hs_prev = 1'b0;
		vs_level = 1'b0;
		for (int i = 0; i < PIXELS; i++) begin
			last_pix[i] = '0;
		end
		repeat (2) @(posedge clk_sys);
		reset_i <= 1'b0;
		// quiet outputs until the first hsync
		mode = 0;
		repeat (6) @(posedge clk_sys);
		// bypass lines with the third one in vblank
		for (int i = 0; i < 4; i++) begin
			drive_line(1, i == 2, vs_level, scandoubler_pkg::SL_NONE);
		end
		// doubled without scanlines settles for three lines before the checks
		for (int i = 0; i < 7; i++) begin
			drive_line(i < 3 ? 2 : 3, 1'b0, vs_level, scandoubler_pkg::SL_NONE);
		end
		// each scanline level starts with a vs change
		for (int m = 1; m < 4; m++) begin
			vs_level = ~vs_level;
			drive_line(2, 1'b0, vs_level, scandoubler_pkg::scanline_mode_t'(m));
			for (int i = 0; i < 3; i++) begin
				drive_line(3, 1'b0, vs_level, scandoubler_pkg::scanline_mode_t'(m));
			end
		end
		// closes the last checked line
		drive_line(2, 1'b0, vs_level, scandoubler_pkg::SL_NONE);
		$display("Simulation passed");
		$finish;
	end

endmodule

//--- design/scandoubler_top.sv
`timescale 1ns/1ps
`include "scandoubler_cfg.svh"

module scandoubler_top (
	input  logic                            clk_sys,
	input  logic                            reset_i,
	// mode controls
	input  logic                            bypass_i,
	input  scandoubler_pkg::ce_div_t        ce_divider_i,
	input  scandoubler_pkg::scanline_mode_t scanlines_i,
	// low-rate video in
	input  logic                            hb_i,
	input  logic                            vb_i,
	input  logic                            hs_i,
	input  logic                            vs_i,
	input  scandoubler_pkg::rgb_in_t        rgb_i,
	// doubled or bypassed video out
	output logic                            hb_o,
	output logic                            vb_o,
	output logic                            hs_o,
	output logic                            vs_o,
	output logic [`SD_OUT_DEPTH-1:0]        r_o,
	output logic [`SD_OUT_DEPTH-1:0]        g_o,
	output logic [`SD_OUT_DEPTH-1:0]        b_o,
	output logic                            pixel_ena_o
);

	// ========================================
	// internal nets
	// ========================================

	// capture to buffer and timing
	logic ce_x1;
	logic wr_en;
	logic [`SD_HCNT_WIDTH:0] wr_addr;
	scandoubler_pkg::buf_word_t wr_data;
	logic line_toggle;
	scandoubler_pkg::sync_cnt_t hs_half_len;
	scandoubler_pkg::sync_cnt_t hs_rise_pos;
	scandoubler_pkg::ce_div_t ce_div_out;

	// timing to buffer and mixer
	logic ce_x2;
	logic rd_en;
	logic [`SD_HCNT_WIDTH:0] rd_addr;
	scandoubler_pkg::buf_word_t rd_data;
	logic hs_sd;
	logic hb_sd;
	logic vb_sd;

	// ========================================
	// blocks
	// ========================================

	input_line_capture u_capture (
		.clk_sys       (clk_sys),
		.reset_i       (reset_i),
		.ce_divider_i  (ce_divider_i),
		.hs_i          (hs_i),
		.vs_i          (vs_i),
		.hb_i          (hb_i),
		.vb_i          (vb_i),
		.rgb_i         (rgb_i),
		.ce_x1_o       (ce_x1),
		.wr_en_o       (wr_en),
		.wr_addr_o     (wr_addr),
		.wr_data_o     (wr_data),
		.line_toggle_o (line_toggle),
		.hs_half_len_o (hs_half_len),
		.hs_rise_pos_o (hs_rise_pos),
		.ce_div_out_o  (ce_div_out)
	);

	line_buffer u_buffer (
		.clk_sys   (clk_sys),
		.wr_en_i   (wr_en),
		.wr_addr_i (wr_addr),
		.wr_data_i (wr_data),
		.rd_en_i   (rd_en),
		.rd_addr_i (rd_addr),
		.rd_data_o (rd_data)
	);

	output_line_timing u_timing (
		.clk_sys       (clk_sys),
		.reset_i       (reset_i),
		.hs_i          (hs_i),
		.line_toggle_i (line_toggle),
		.hs_half_len_i (hs_half_len),
		.hs_rise_pos_i (hs_rise_pos),
		.ce_div_out_i  (ce_div_out),
		.ce_divider_i  (ce_divider_i),
		.rd_data_i     (rd_data),
		.ce_x2_o       (ce_x2),
		.rd_en_o       (rd_en),
		.rd_addr_o     (rd_addr),
		.hs_sd_o       (hs_sd),
		.hb_sd_o       (hb_sd),
		.vb_sd_o       (vb_sd)
	);

	// colour comes straight from the buffer word
	scanline_mixer u_mixer (
		.clk_sys     (clk_sys),
		.reset_i     (reset_i),
		.bypass_i    (bypass_i),
		.scanlines_i (scanlines_i),
		.ce_x1_i     (ce_x1),
		.ce_x2_i     (ce_x2),
		.rgb_in_i    (rgb_i),
		.hb_i        (hb_i),
		.vb_i        (vb_i),
		.hs_i        (hs_i),
		.vs_i        (vs_i),
		.rd_rgb_i    (rd_data.rgb),
		.hs_sd_i     (hs_sd),
		.hb_sd_i     (hb_sd),
		.vb_sd_i     (vb_sd),
		.r_o         (r_o),
		.g_o         (g_o),
		.b_o         (b_o),
		.hb_o        (hb_o),
		.vb_o        (vb_o),
		.hs_o        (hs_o),
		.vs_o        (vs_o),
		.pixel_ena_o (pixel_ena_o)
	);

endmodule

//--- design/scanline_mixer.sv
`timescale 1ns/1ps
`include "scandoubler_cfg.svh"

module scanline_mixer (
	input  logic                            clk_sys,
	input  logic                            reset_i,
	input  logic                            bypass_i,
	input  scandoubler_pkg::scanline_mode_t scanlines_i,
	input  logic                            ce_x1_i,
	input  logic                            ce_x2_i,
	input  scandoubler_pkg::rgb_in_t        rgb_in_i,
	input  logic                            hb_i,
	input  logic                            vb_i,
	input  logic                            hs_i,
	input  logic                            vs_i,
	input  scandoubler_pkg::rgb_in_t        rd_rgb_i,
	input  logic                            hs_sd_i,
	input  logic                            hb_sd_i,
	input  logic                            vb_sd_i,
	output logic [`SD_OUT_DEPTH-1:0]        r_o,
	output logic [`SD_OUT_DEPTH-1:0]        g_o,
	output logic [`SD_OUT_DEPTH-1:0]        b_o,
	output logic                            hb_o,
	output logic                            vb_o,
	output logic                            hs_o,
	output logic                            vs_o,
	output logic                            pixel_ena_o
);

	localparam int CD = `SD_COLOR_DEPTH;
	localparam int OD = `SD_OUT_DEPTH;

	// fill the low bits by repeating the colour from its top bit down
	function automatic logic [OD-1:0] widen(input logic [CD-1:0] c);
		logic [OD-1:0] w;
		for (int i = 0; i < OD; i++) begin
			w[OD-1-i] = c[CD-1-(i % CD)];
		end
		return w;
	endfunction

	scandoubler_pkg::rgb_in_t src;
	logic [OD-1:0] r_w;
	logic [OD-1:0] g_w;
	logic [OD-1:0] b_w;
	logic [6:0] coeff;
	logic [OD+6:0] r_mul;
	logic [OD+6:0] g_mul;
	logic [OD+6:0] b_mul;
	logic dim_line;
	logic hs_q;
	logic vs_q;
	logic blank;

	// ========================================
	// colour path
	// ========================================

	assign src = bypass_i ? rgb_in_i : rd_rgb_i;
	assign r_w = widen(src.r);
	assign g_w = widen(src.g);
	assign b_w = widen(src.b);

	// 0x40 is unity, result taken from bits 11:6
	always_comb begin
		coeff = 7'h40;
		if (dim_line && !bypass_i) begin
			case (scanlines_i)
				scandoubler_pkg::SL_25: coeff = 7'h3a;
				scandoubler_pkg::SL_50: coeff = 7'h2e;
				scandoubler_pkg::SL_75: coeff = 7'h1a;
				default: coeff = 7'h40;
			endcase
		end
	end

	// ========================================
	// doubled output registers
	// ========================================

	// dim flag flips on every regenerated hsync fall
	// a vs change restarts the pattern and takes priority
	always_ff @(posedge clk_sys) begin
		if (reset_i) begin
			hs_q <= 1'b0;
			vs_q <= 1'b0;
			dim_line <= 1'b0;
			r_mul <= '0;
			g_mul <= '0;
			b_mul <= '0;
		end else if (ce_x2_i) begin
			hs_q <= hs_sd_i;
			vs_q <= vs_i;
			if (vs_q != vs_i) begin
				dim_line <= 1'b0;
			end else if (hs_q && !hs_sd_i) begin
				dim_line <= ~dim_line;
			end
			r_mul <= r_w * coeff;
			g_mul <= g_w * coeff;
			b_mul <= b_w * coeff;
		end
	end

	// ========================================
	// output select
	// ========================================

	assign hb_o = bypass_i ? hb_i : hb_sd_i;
	assign vb_o = bypass_i ? vb_i : vb_sd_i;
	assign hs_o = bypass_i ? hs_i : hs_q;
	assign vs_o = bypass_i ? vs_i : vs_q;
	assign pixel_ena_o = bypass_i ? ce_x1_i : ce_x2_i;

	// black during any blanking
	assign blank = hb_o | vb_o;
	assign r_o = blank ? '0 : (bypass_i ? r_w : r_mul[2*OD-1:OD]);
	assign g_o = blank ? '0 : (bypass_i ? g_w : g_mul[2*OD-1:OD]);
	assign b_o = blank ? '0 : (bypass_i ? b_w : b_mul[2*OD-1:OD]);

endmodule

//--- design/output_line_timing.sv
`timescale 1ns/1ps
`include "scandoubler_cfg.svh"

module output_line_timing (
	input  logic                       clk_sys,
	input  logic                       reset_i,
	input  logic                       hs_i,
	input  logic                       line_toggle_i,
	input  scandoubler_pkg::sync_cnt_t hs_half_len_i,
	input  scandoubler_pkg::sync_cnt_t hs_rise_pos_i,
	input  scandoubler_pkg::ce_div_t   ce_div_out_i,
	input  scandoubler_pkg::ce_div_t   ce_divider_i,
	input  scandoubler_pkg::buf_word_t rd_data_i,
	output logic                       ce_x2_o,
	output logic                       rd_en_o,
	output logic [`SD_HCNT_WIDTH:0]    rd_addr_o,
	output logic                       hs_sd_o,
	output logic                       hb_sd_o,
	output logic                       vb_sd_o
);

	scandoubler_pkg::ce_div_t div_lim;
	scandoubler_pkg::ce_div_t sd_i_div;
	scandoubler_pkg::line_pos_t sd_hcnt;
	scandoubler_pkg::sync_cnt_t sd_synccnt;
	logic hs_d;
	logic hs_fall;
	logic sync_wrap;
	// first hsync seen, sync output may run
	logic armed;
	// one full line stored, buffer reads are meaningful
	logic ready;
	// rd_data holds a word read while ready
	logic rd_valid;

	assign div_lim = scandoubler_pkg::ce_div_limit(ce_divider_i);
	assign hs_fall = hs_d & ~hs_i;
	assign sync_wrap = (sd_synccnt == hs_half_len_i) | hs_fall;

	// strobe at the limit and at half of it, two per input pixel
	assign ce_x2_o = armed & ((sd_i_div == ce_div_out_i) |
		(sd_i_div == {1'b0, ce_div_out_i[2:1]}));

	// read the line not being written
	assign rd_en_o = ce_x2_o & ready;
	assign rd_addr_o = {~line_toggle_i, sd_hcnt};

	// ========================================
	// start-up
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (reset_i) begin
			hs_d <= 1'b0;
			armed <= 1'b0;
			ready <= 1'b0;
		end else begin
			hs_d <= hs_i;
			if (hs_fall) begin
				armed <= 1'b1;
				ready <= armed;
			end
		end
	end

	// ========================================
	// half-line counters
	// ========================================

	// wraps twice per input line, input hsync realigns it
	always_ff @(posedge clk_sys) begin
		if (reset_i) begin
			sd_synccnt <= '0;
			sd_hcnt <= '0;
		end else if (sync_wrap) begin
			sd_synccnt <= '0;
			sd_hcnt <= '0;
		end else begin
			sd_synccnt <= sd_synccnt + 1'b1;
			if (ce_x2_o) begin
				sd_hcnt <= sd_hcnt + 1'b1;
			end
		end
	end

	// output divider, phase locked to the half-line start
	always_ff @(posedge clk_sys) begin
		if (reset_i) begin
			sd_i_div <= '0;
		end else if (sd_synccnt == '0) begin
			sd_i_div <= '0;
		end else if (sd_i_div == div_lim) begin
			sd_i_div <= '0;
		end else begin
			sd_i_div <= sd_i_div + 3'd1;
		end
	end

	// regenerated hsync, low from half-line start to the rise point
	always_ff @(posedge clk_sys) begin
		if (reset_i) begin
			hs_sd_o <= 1'b0;
		end else if (armed) begin
			if (sd_synccnt == hs_rise_pos_i) begin
				hs_sd_o <= 1'b1;
			end else if (sd_synccnt == '0) begin
				hs_sd_o <= 1'b0;
			end
		end
	end

	// ========================================
	// blanking replay
	// ========================================

	// blank until real line data comes back from the buffer
	always_ff @(posedge clk_sys) begin
		if (reset_i) begin
			rd_valid <= 1'b0;
			hb_sd_o <= 1'b0;
			vb_sd_o <= 1'b0;
		end else if (ce_x2_o) begin
			rd_valid <= ready;
			if (rd_valid) begin
				hb_sd_o <= rd_data_i.hb;
				if (rd_data_i.vb_on) begin
					vb_sd_o <= 1'b1;
				end
				if (rd_data_i.vb_off) begin
					vb_sd_o <= 1'b0;
				end
			end else begin
				hb_sd_o <= 1'b1;
			end
		end
	end

endmodule

//--- design/input_line_capture.sv
`timescale 1ns/1ps
`include "scandoubler_cfg.svh"

module input_line_capture (
	input  logic                       clk_sys,
	input  logic                       reset_i,
	input  scandoubler_pkg::ce_div_t   ce_divider_i,
	input  logic                       hs_i,
	input  logic                       vs_i,
	input  logic                       hb_i,
	input  logic                       vb_i,
	input  scandoubler_pkg::rgb_in_t   rgb_i,
	output logic                       ce_x1_o,
	output logic                       wr_en_o,
	output logic [`SD_HCNT_WIDTH:0]    wr_addr_o,
	output scandoubler_pkg::buf_word_t wr_data_o,
	output logic                       line_toggle_o,
	output scandoubler_pkg::sync_cnt_t hs_half_len_o,
	output scandoubler_pkg::sync_cnt_t hs_rise_pos_o,
	output scandoubler_pkg::ce_div_t   ce_div_out_o
);

	scandoubler_pkg::ce_div_t div_lim;
	scandoubler_pkg::ce_div_t ce_div_in;
	scandoubler_pkg::ce_div_t i_div;
	scandoubler_pkg::line_pos_t hcnt;
	scandoubler_pkg::sync_cnt_t synccnt;
	logic hs_d;
	logic vs_d;
	logic vb_d;
	logic hs_fall;
	logic hs_rise;

	assign div_lim = scandoubler_pkg::ce_div_limit(ce_divider_i);
	assign hs_fall = hs_d & ~hs_i;
	assign hs_rise = ~hs_d & hs_i;

	// pixel strobe uses the limit latched at the last hsync
	assign ce_x1_o = (i_div == ce_div_in);

	// ========================================
	// buffer write
	// ========================================

	assign wr_en_o = ce_x1_o;
	assign wr_addr_o = {line_toggle_o, hcnt};

	// vblank is stored as edges so the replay can rebuild it
	always_comb begin
		wr_data_o.vb_off = vb_d & ~vb_i;
		wr_data_o.vb_on = ~vb_d & vb_i;
		wr_data_o.hb = hb_i;
		wr_data_o.rgb = rgb_i;
	end

	// sync edge detect, vblank sampled per pixel
	always_ff @(posedge clk_sys) begin
		if (reset_i) begin
			hs_d <= 1'b0;
			vs_d <= 1'b0;
			vb_d <= 1'b0;
		end else begin
			hs_d <= hs_i;
			vs_d <= vs_i;
			if (ce_x1_o) begin
				vb_d <= vb_i;
			end
		end
	end

	// ========================================
	// input pixel divider
	// ========================================

	// restarts at hsync so pixels stay aligned to the line
	// the old limit moves on to the output side
	always_ff @(posedge clk_sys) begin
		if (reset_i) begin
			i_div <= '0;
			ce_div_in <= 3'd3;
			ce_div_out_o <= 3'd3;
		end else if (hs_fall) begin
			i_div <= '0;
			ce_div_in <= div_lim;
			ce_div_out_o <= ce_div_in;
		end else if (i_div == div_lim) begin
			i_div <= '0;
		end else begin
			i_div <= i_div + 3'd1;
		end
	end

	// pixel position in the line
	always_ff @(posedge clk_sys) begin
		if (reset_i) begin
			hcnt <= '0;
		end else if (hs_fall) begin
			hcnt <= '0;
		end else if (ce_x1_o) begin
			hcnt <= hcnt + 1'b1;
		end
	end

	// ========================================
	// line measurement
	// ========================================

	// clk_sys count since hsync fall
	// both results halved for the doubled line
	always_ff @(posedge clk_sys) begin
		if (reset_i) begin
			synccnt <= '0;
			hs_half_len_o <= '0;
			hs_rise_pos_o <= '0;
		end else begin
			synccnt <= synccnt + 1'b1;
			if (hs_fall) begin
				synccnt <= '0;
				hs_half_len_o <= {1'b0, synccnt[`SD_HSCNT_WIDTH:1]};
			end
			if (hs_rise) begin
				hs_rise_pos_o <= {1'b0, synccnt[`SD_HSCNT_WIDTH:1]};
			end
		end
	end

	// buffer half select, back to line 0 on each vs change
	always_ff @(posedge clk_sys) begin
		if (reset_i) begin
			line_toggle_o <= 1'b0;
		end else if (vs_d != vs_i) begin
			line_toggle_o <= 1'b0;
		end else if (hs_fall) begin
			line_toggle_o <= ~line_toggle_o;
		end
	end

endmodule

//--- design/line_buffer.sv
`timescale 1ns/1ps
`include "scandoubler_cfg.svh"

module line_buffer (
	input  logic                       clk_sys,
	// write side, from the input capture
	input  logic                       wr_en_i,
	input  logic [`SD_HCNT_WIDTH:0]    wr_addr_i,
	input  scandoubler_pkg::buf_word_t wr_data_i,
	// read side, from the output timing
	input  logic                       rd_en_i,
	input  logic [`SD_HCNT_WIDTH:0]    rd_addr_i,
	output scandoubler_pkg::buf_word_t rd_data_o
);

	// two lines back to back, top address bit picks the line
	localparam int DEPTH = 2 ** (`SD_HCNT_WIDTH + 1);

	scandoubler_pkg::buf_word_t mem [0:DEPTH-1];

	// ========================================
	// write port
	// ========================================

	// one word per input pixel strobe
	always_ff @(posedge clk_sys) begin
		if (wr_en_i) begin
			mem[wr_addr_i] <= wr_data_i;
		end
	end

	// ========================================
	// read port
	// ========================================

	// registered read, data one cycle after rd_en
	// the two sides always work on opposite lines
	always_ff @(posedge clk_sys) begin
		if (rd_en_i) begin
			rd_data_o <= mem[rd_addr_i];
		end
	end

endmodule

//--- design/scandoubler_pkg.sv
`include "scandoubler_cfg.svh"

package scandoubler_pkg;

	// ========================================
	// pixel and buffer words
	// ========================================

	// input colour triple, red on top
	typedef struct packed {
		logic [`SD_COLOR_DEPTH-1:0] r;
		logic [`SD_COLOR_DEPTH-1:0] g;
		logic [`SD_COLOR_DEPTH-1:0] b;
	} rgb_in_t;

	// one stored pixel with its blanking flags
	typedef struct packed {
		// vblank falling edge seen on this pixel
		logic vb_off;
		// vblank rising edge seen on this pixel
		logic vb_on;
		logic hb;
		rgb_in_t rgb;
	} buf_word_t;

	// ========================================
	// counters and modes
	// ========================================

	// divider limit, counter runs 0..limit
	typedef logic [2:0] ce_div_t;

	typedef enum logic [1:0] {
		SL_NONE = 2'd0,
		SL_25 = 2'd1,
		SL_50 = 2'd2,
		SL_75 = 2'd3
	} scanline_mode_t;

	typedef logic [`SD_HCNT_WIDTH-1:0] line_pos_t;
	typedef logic [`SD_HSCNT_WIDTH:0] sync_cnt_t;

	// a limit of 0 means clk_sys/4
	function automatic ce_div_t ce_div_limit(input ce_div_t div);
		return (div == 3'd0) ? 3'd3 : div;
	endfunction

endpackage

//--- include/scandoubler_cfg.svh
`ifndef SCANDOUBLER_CFG_SVH
`define SCANDOUBLER_CFG_SVH

// ========================================
// line buffer geometry
// ========================================

// pixel address bits of one buffer line
`define SD_HCNT_WIDTH 9

// ========================================
// colour and sync widths
// ========================================

// bits per colour at the input (1, 2, 4 or 6)
`define SD_COLOR_DEPTH 4
// bits per colour at the output
`define SD_OUT_DEPTH 6
// clk_sys line length counters, one extra bit is added in the package
`define SD_HSCNT_WIDTH 12

`endif
